/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_redmule -f tb.f
status=0
out=$(./obj_dir/Vtb_redmule 2>&1) || status=$?
echo "$out"
if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1

/* tb.f */
+incdir+include
verilog/redmule_cfg_pkg.sv
verilog/redmule_bus_pkg.sv
verilog/redmule_x_buffer.sv
verilog/redmule_engine.sv
verilog/redmule_scheduler.sv
verilog/redmule_ctrl.sv
verilog/redmule_top.sv
verification/tb_redmule.sv

/* include/redmule_tb_tasks.svh */
// Testbench AXI4-Lite tasks, operand stream driver, reference model and
// queue of expected results
`ifndef REDMULE_TB_TASKS_SVH
`define REDMULE_TB_TASKS_SVH

// Every task is entered and left at a falling clock edge
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          input logic [1:0] resp);
  int waited;
  exp_bresp = resp;
  axil_req.aw_valid = 1'b1;
  axil_req.aw_addr  = addr;
  axil_req.w_valid  = 1'b1;
  axil_req.w_data   = data;
  axil_req.w_strb   = 4'hf;
  waited = 0;
  #1;
  while (!axil_rsp.aw_ready) begin
    @(negedge clk_i);
    waited++;
    if (waited > TimeoutCycles) timeout_fail("Timeout waiting for the AXI write address ready");
    #1;
  end
  @(negedge clk_i);
  axil_req.aw_valid = 1'b0;
  axil_req.w_valid  = 1'b0;
  waited = 0;
  while (!axil_rsp.b_valid) begin
    @(negedge clk_i);
    waited++;
    if (waited > TimeoutCycles) timeout_fail("Timeout waiting for the AXI write response");
  end
  @(negedge clk_i);
endtask

task automatic axil_read(input logic [7:0] addr, input logic [31:0] data,
                         input logic [1:0] resp);
  int waited;
  exp_rdata = data;
  exp_rresp = resp;
  axil_req.ar_valid = 1'b1;
  axil_req.ar_addr  = addr;
  waited = 0;
  #1;
  while (!axil_rsp.ar_ready) begin
    @(negedge clk_i);
    waited++;
    if (waited > TimeoutCycles) timeout_fail("Timeout waiting for the AXI read address ready");
    #1;
  end
  @(negedge clk_i);
  axil_req.ar_valid = 1'b0;
  waited = 0;
  while (!axil_rsp.r_valid) begin
    @(negedge clk_i);
    waited++;
    if (waited > TimeoutCycles) timeout_fail("Timeout waiting for the AXI read data");
  end
  @(negedge clk_i);
endtask

// One word on the operand stream with random idle cycles in random mode
task automatic send_word(input logic [31:0] data, input bit is_y);
  int waited;
  while (rand_mode && (($random(seed) & 3) == 0)) @(negedge clk_i);
  op_in.valid = 1'b1;
  op_in.data  = data;
  y_mark      = is_y;
  waited = 0;
  #1;
  while (!op_ready) begin
    @(negedge clk_i);
    waited++;
    if (waited > TimeoutCycles) timeout_fail("Timeout waiting for the operand stream ready");
    #1;
  end
  @(negedge clk_i);
  op_in.valid = 1'b0;
  y_mark      = 1'b0;
endtask

// Reference Z[r] = Y[r] + sum over c of X[r][c] * W[c] in signed arithmetic
function automatic logic [Rows-1:0][AccW-1:0] ref_z(input redmule_cfg_pkg::x_matrix_t x,
                                                     input logic [31:0] w,
                                                     input logic [31:0] y);
  logic [Rows-1:0][AccW-1:0] z;
  logic signed [AccW-1:0]    acc;
  logic signed [7:0]         a;
  logic signed [7:0]         b;
  for (int r = 0; r < Rows; r++) begin
    a   = y[r*8 +: 8];
    acc = a;
    for (int c = 0; c < Cols; c++) begin
      a   = x[r][c];
      b   = w[c*8 +: 8];
      acc = acc + a * b;
    end
    z[r] = acc;
  end
  return z;
endfunction

task automatic push_expected(input logic [Rows-1:0][AccW-1:0] z);
  exp_mem[wr_idx] = z;
  wr_idx++;
endtask

`endif

/* verification/tb_redmule.sv */
// Testbench for the matrix-vector accelerator
// Clock, reset, DUT, assertions and the test sequence
`timescale 1ns/10ps

module tb_redmule;

  localparam int unsigned NumPipeRegs   = 3;
  localparam int unsigned Rows          = redmule_cfg_pkg::ARRAY_WIDTH;
  localparam int unsigned Cols          = redmule_cfg_pkg::ARRAY_HEIGHT;
  localparam int unsigned AccW          = redmule_cfg_pkg::ACC_W;
  localparam int          TimeoutCycles = 2000;

  logic                        clk_i = 1'b0;
  logic                        arst_n_i;
  redmule_bus_pkg::axil_req_t  axil_req;
  redmule_bus_pkg::axil_rsp_t  axil_rsp;
  redmule_bus_pkg::op_stream_t op_in;
  logic                        op_ready;
  redmule_bus_pkg::z_stream_t  z_out;
  logic                        z_ready;
  logic                        busy;
  logic                        evt;

  int          seed;
  bit          rand_mode;
  bit          y_mark;
  bit          check_latency;
  logic [31:0] exp_rdata;
  logic [1:0]  exp_rresp;
  logic [1:0]  exp_bresp;
  int          wr_idx;
  int          rd_idx;
  logic [Rows-1:0][AccW-1:0] exp_mem [0:63];

  always #2 clk_i = ~clk_i;

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic timeout_fail(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  `include "redmule_tb_tasks.svh"

  redmule_top #(
    .NumPipeRegs ( NumPipeRegs )
  ) u_dut (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .axil_req_i ( axil_req ),
    .axil_rsp_o ( axil_rsp ),
    .op_i       ( op_in    ),
    .op_ready_o ( op_ready ),
    .z_o        ( z_out    ),
    .z_ready_i  ( z_ready  ),
    .busy_o     ( busy     ),
    .evt_o      ( evt      )
  );

  // Output back-pressure is random only in random mode
  always @(negedge clk_i) begin
    z_ready = rand_mode ? (($random(seed) & 1) == 1) : 1'b1;
  end

  always @(posedge clk_i) begin
    if (z_out.valid && z_ready) rd_idx <= rd_idx + 1;
  end

  assert property (@(posedge clk_i) $rose(arst_n_i) |-> !busy && !evt && !op_ready &&
                   !z_out.valid && !axil_rsp.b_valid && !axil_rsp.r_valid)
    else mismatch("outputs not idle after reset");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   axil_rsp.w_ready == axil_rsp.aw_ready)
    else mismatch("write data ready differs from write address ready");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   axil_rsp.r_valid && axil_req.r_ready |->
                   axil_rsp.r_data == exp_rdata && axil_rsp.r_resp == exp_rresp)
    else mismatch("wrong read data or read response");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   axil_rsp.b_valid && axil_req.b_ready |-> axil_rsp.b_resp == exp_bresp)
    else mismatch("wrong write response");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   z_out.valid && z_ready |-> rd_idx < wr_idx && z_out.data == exp_mem[rd_idx])
    else mismatch("wrong or unexpected Z result");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   check_latency && op_in.valid && op_ready && y_mark |->
                   ##(NumPipeRegs+1) z_out.valid)
    else mismatch("Z result late or missing after its Y word");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   z_out.valid && !z_ready |=> z_out.valid && $stable(z_out.data))
    else mismatch("Z changed while stalled");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   evt |-> $past(z_out.valid && z_ready) && rd_idx == wr_idx &&
                   !busy && $past(busy))
    else mismatch("event not in the cycle after the last Z transfer");

  assert property (@(posedge clk_i) disable iff (!arst_n_i) evt |=> !evt)
    else mismatch("event longer than one cycle");

  assert property (@(posedge clk_i) disable iff (!arst_n_i) $fell(busy) |-> evt)
    else mismatch("busy fell without the event");

  task automatic run_job(input int size_n, input bit mid_start);
    redmule_cfg_pkg::x_matrix_t x_tb;
    logic [31:0] w_v [0:15];
    logic [31:0] y_v [0:15];
    int          waited;
    for (int r = 0; r < Rows; r++) begin
      for (int c = 0; c < Cols; c++) begin
        x_tb[r][c] = rand_mode ? 8'($random(seed)) : 8'(r * 7 - c * 5 + 3);
      end
    end
    for (int v = 0; v < size_n; v++) begin
      for (int e = 0; e < 4; e++) begin
        w_v[v][e*8 +: 8] = rand_mode ? 8'($random(seed)) : 8'(v * 11 + e * 3 - 9);
        y_v[v][e*8 +: 8] = rand_mode ? 8'($random(seed)) : 8'(v * 5 - e * 13);
      end
      push_expected(ref_z(x_tb, w_v[v], y_v[v]));
    end
    axil_write(redmule_cfg_pkg::REG_SIZE_N, 32'(size_n), redmule_bus_pkg::AXIL_RESP_OKAY);
    axil_write(redmule_cfg_pkg::REG_CTRL, 32'h1, redmule_bus_pkg::AXIL_RESP_OKAY);
    for (int r = 0; r < Rows; r++) send_word(x_tb[r], 1'b0);
    for (int v = 0; v < size_n; v++) begin
      send_word(w_v[v], 1'b0);
      // A second start inside the job must be ignored
      if (mid_start && v == 1) begin
        axil_write(redmule_cfg_pkg::REG_CTRL, 32'h1, redmule_bus_pkg::AXIL_RESP_OKAY);
      end
      send_word(y_v[v], 1'b1);
    end
    waited = 0;
    while (!evt) begin
      @(negedge clk_i);
      waited++;
      if (waited > TimeoutCycles) timeout_fail("Timeout waiting for the end of job event");
    end
    @(negedge clk_i);
  endtask

  initial begin
    seed          = 32'h1386;
    rand_mode     = 1'b0;
    y_mark        = 1'b0;
    check_latency = 1'b0;
    wr_idx        = 0;
    exp_rdata     = '0;
    exp_rresp     = '0;
    exp_bresp     = '0;
    axil_req      = '0;
    axil_req.b_ready = 1'b1;
    axil_req.r_ready = 1'b1;
    op_in         = '0;
    z_ready       = 1'b1;
    arst_n_i      = 1'b0;
    repeat (16) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    axil_read(redmule_cfg_pkg::REG_SIZE_N, 32'h1, redmule_bus_pkg::AXIL_RESP_OKAY);
    axil_write(redmule_cfg_pkg::REG_SIZE_N, 32'h5, redmule_bus_pkg::AXIL_RESP_OKAY);
    axil_read(redmule_cfg_pkg::REG_SIZE_N, 32'h5, redmule_bus_pkg::AXIL_RESP_OKAY);
    axil_read(8'h20, 32'h0, redmule_bus_pkg::AXIL_RESP_SLVERR);
    axil_write(redmule_cfg_pkg::REG_JOBS, 32'h55, redmule_bus_pkg::AXIL_RESP_OKAY);
    axil_read(redmule_cfg_pkg::REG_JOBS, 32'h0, redmule_bus_pkg::AXIL_RESP_OKAY);

    // Fixed operands, no back-pressure, exact latency
    check_latency = 1'b1;
    run_job(3, 1'b0);
    check_latency = 1'b0;
    axil_read(redmule_cfg_pkg::REG_JOBS, 32'h1, redmule_bus_pkg::AXIL_RESP_OKAY);
    axil_read(redmule_cfg_pkg::REG_STATUS, 32'h2, redmule_bus_pkg::AXIL_RESP_OKAY);

    // Random operands, gaps and stalls
    rand_mode = 1'b1;
    run_job(8, 1'b1);
    rand_mode = 1'b0;
    repeat (4) @(negedge clk_i);
    axil_read(redmule_cfg_pkg::REG_JOBS, 32'h2, redmule_bus_pkg::AXIL_RESP_OKAY);
    axil_read(redmule_cfg_pkg::REG_STATUS, 32'h2, redmule_bus_pkg::AXIL_RESP_OKAY);
    repeat (4) @(negedge clk_i);

    if (rd_idx == wr_idx) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Only %0d of %0d expected Z results were received", rd_idx, wr_idx);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Checks failed");
    end
  end

endmodule

/* verilog/redmule_bus_pkg.sv */
// AXI4-Lite channel structs, response codes and the operand and result
// stream structs
package redmule_bus_pkg;

  localparam int unsigned AXIL_ADDR_W = 8;
  localparam int unsigned AXIL_DATA_W = 32;

  localparam logic [1:0] AXIL_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_RESP_SLVERR = 2'b10;

  // Manager driven fields
  typedef struct packed {
    logic                     aw_valid;
    logic [AXIL_ADDR_W-1:0]   aw_addr;
    logic                     w_valid;
    logic [AXIL_DATA_W-1:0]   w_data;
    logic [AXIL_DATA_W/8-1:0] w_strb;
    logic                     b_ready;
    logic                     ar_valid;
    logic [AXIL_ADDR_W-1:0]   ar_addr;
    logic                     r_ready;
  } axil_req_t;

  // Subordinate driven fields
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    logic [1:0]             b_resp;
    logic                   ar_ready;
    logic                   r_valid;
    logic [AXIL_DATA_W-1:0] r_data;
    logic [1:0]             r_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic                             valid;
    logic [redmule_cfg_pkg::OP_W-1:0] data;
  } op_stream_t;

  typedef struct packed {
    logic valid;
    logic [redmule_cfg_pkg::ARRAY_WIDTH-1:0][redmule_cfg_pkg::ACC_W-1:0] data;
  } z_stream_t;

endpackage

/* verilog/redmule_cfg_pkg.sv */
// Array geometry, operand and accumulator widths, register offsets
// and the datapath struct types
package redmule_cfg_pkg;

  // Array geometry
  // Y words carry ARRAY_WIDTH elements in an OP_W word, so the array must be square
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned ARRAY_WIDTH  = 4;

  localparam int unsigned ELEM_W = 8;
  localparam int unsigned ACC_W  = 32;
  localparam int unsigned OP_W   = ARRAY_HEIGHT * ELEM_W;
  localparam int unsigned SIZE_W = 16;
  localparam int unsigned ROW_W  = $clog2(ARRAY_WIDTH);

  // Register byte offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_STATUS = 8'h04;
  localparam logic [7:0] REG_SIZE_N = 8'h08;
  localparam logic [7:0] REG_JOBS   = 8'h0C;

  typedef logic [ARRAY_WIDTH-1:0][ARRAY_HEIGHT-1:0][ELEM_W-1:0] x_matrix_t;

  typedef struct packed {
    logic                              valid;
    logic [ARRAY_HEIGHT-1:0][ELEM_W-1:0] w;
    logic [ARRAY_WIDTH-1:0][ELEM_W-1:0]  y;
  } engine_req_t;

  typedef struct packed {
    logic              start;
    logic [SIZE_W-1:0] size_n;
  } job_cfg_t;

endpackage

/* verilog/redmule_ctrl.sv */
// AXI4-Lite register slave with start, status, size and job count
// Also drives busy and the end-of-job event
`timescale 1ns/10ps

module redmule_ctrl (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  redmule_bus_pkg::axil_req_t axil_req_i,
  output redmule_bus_pkg::axil_rsp_t axil_rsp_o,
  input  logic                       job_done_i,
  output redmule_cfg_pkg::job_cfg_t  job_cfg_o,
  output logic                       busy_o,
  output logic                       evt_o
);

  logic                                    wr_fire;
  logic                                    rd_fire;
  logic                                    start_req;
  logic                                    b_valid_q;
  logic                                    r_valid_q;
  logic [1:0]                              b_resp_q;
  logic [1:0]                              r_resp_q;
  logic [redmule_bus_pkg::AXIL_DATA_W-1:0] r_data_q;
  logic [redmule_bus_pkg::AXIL_DATA_W-1:0] rd_data;
  logic                                    start_q;
  logic                                    busy_q;
  logic                                    done_q;
  logic                                    evt_q;
  logic [redmule_cfg_pkg::SIZE_W-1:0]      size_n_q;
  logic [redmule_bus_pkg::AXIL_DATA_W-1:0] jobs_q;

  function automatic logic [1:0] resp_for(input logic [redmule_bus_pkg::AXIL_ADDR_W-1:0] addr);
    logic hit;
    hit = addr inside {redmule_cfg_pkg::REG_CTRL, redmule_cfg_pkg::REG_STATUS,
                       redmule_cfg_pkg::REG_SIZE_N, redmule_cfg_pkg::REG_JOBS};
    return hit ? redmule_bus_pkg::AXIL_RESP_OKAY : redmule_bus_pkg::AXIL_RESP_SLVERR;
  endfunction

  // Address and data are taken together, one write in flight
  assign wr_fire = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
  assign rd_fire = axil_req_i.ar_valid & ~r_valid_q;

  // A start while busy is dropped
  assign start_req = wr_fire & (axil_req_i.aw_addr == redmule_cfg_pkg::REG_CTRL) &
                     axil_req_i.w_strb[0] & axil_req_i.w_data[0] & ~busy_q;

  always_comb begin
    rd_data = '0;
    case (axil_req_i.ar_addr)
      redmule_cfg_pkg::REG_STATUS: rd_data[1:0] = {done_q, busy_q};
      redmule_cfg_pkg::REG_SIZE_N: rd_data[redmule_cfg_pkg::SIZE_W-1:0] = size_n_q;
      redmule_cfg_pkg::REG_JOBS:   rd_data = jobs_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
      start_q   <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      evt_q     <= 1'b0;
      size_n_q  <= redmule_cfg_pkg::SIZE_W'(1);
      jobs_q    <= '0;
    end else begin
      start_q <= start_req;
      evt_q   <= job_done_i;
      if (start_req) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (job_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (job_done_i) begin
        jobs_q <= jobs_q + 1'b1;
      end
      // Byte strobes apply to the size register
      if (wr_fire && axil_req_i.aw_addr == redmule_cfg_pkg::REG_SIZE_N) begin
        for (int b = 0; b < redmule_cfg_pkg::SIZE_W / 8; b++) begin
          if (axil_req_i.w_strb[b]) begin
            size_n_q[b*8 +: 8] <= axil_req_i.w_data[b*8 +: 8];
          end
        end
      end
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= resp_for(axil_req_i.aw_addr);
    end
    if (rd_fire) begin
      r_data_q <= rd_data;
      r_resp_q <= resp_for(axil_req_i.ar_addr);
    end
  end

  assign axil_rsp_o.aw_ready = wr_fire;
  assign axil_rsp_o.w_ready  = wr_fire;
  assign axil_rsp_o.b_valid  = b_valid_q;
  assign axil_rsp_o.b_resp   = b_resp_q;
  assign axil_rsp_o.ar_ready = ~r_valid_q;
  assign axil_rsp_o.r_valid  = r_valid_q;
  assign axil_rsp_o.r_data   = r_data_q;
  assign axil_rsp_o.r_resp   = r_resp_q;

  assign job_cfg_o.start  = start_q;
  assign job_cfg_o.size_n = size_n_q;
  assign busy_o           = busy_q;
  assign evt_o            = evt_q;

endmodule

/* verilog/redmule_engine.sv */
// Pipelined multiply-accumulate array with per-stage valid bits
// and one stall that freezes every stage
`timescale 1ns/10ps

module redmule_engine #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  redmule_cfg_pkg::x_matrix_t   x_i,
  input  redmule_cfg_pkg::engine_req_t req_i,
  output logic                         in_ready_o,
  output redmule_bus_pkg::z_stream_t   z_o,
  input  logic                         z_ready_i
);

  localparam int unsigned Rows = redmule_cfg_pkg::ARRAY_WIDTH;
  localparam int unsigned Cols = redmule_cfg_pkg::ARRAY_HEIGHT;

  typedef logic signed [redmule_cfg_pkg::ACC_W-1:0] acc_elem_t;
  typedef acc_elem_t [Rows-1:0][Cols-1:0] prod_t;
  typedef acc_elem_t [Rows-1:0] acc_t;

  logic             stall;
  logic [NumPipeRegs:0] valid_q;
  prod_t            prod_d;
  acc_t             bias_d;
  prod_t            prod_q [NumPipeRegs];
  acc_t             acc_q  [NumPipeRegs+1];

  // Output held and not taken
  assign stall      = valid_q[NumPipeRegs] & ~z_ready_i;
  assign in_ready_o = ~stall;

  // Stage 0 forms the signed products and the extended bias
  always_comb begin
    for (int r = 0; r < Rows; r++) begin
      bias_d[r] = acc_elem_t'($signed(req_i.y[r]));
      for (int c = 0; c < Cols; c++) begin
        prod_d[r][c] = acc_elem_t'($signed(x_i[r][c])) * acc_elem_t'($signed(req_i.w[c]));
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q <= {valid_q[NumPipeRegs-1:0], req_i.valid};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      prod_q[0] <= prod_d;
      acc_q[0]  <= bias_d;
    end
  end

  // Each later stage adds its share of columns, c mod NumPipeRegs
  for (genvar k = 1; k <= NumPipeRegs; k++) begin : gen_stage
    acc_t sum_d;

    always_comb begin
      sum_d = acc_q[k-1];
      for (int r = 0; r < Rows; r++) begin
        for (int c = 0; c < Cols; c++) begin
          if (c % NumPipeRegs == k - 1) sum_d[r] = sum_d[r] + prod_q[k-1][r][c];
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (!stall) acc_q[k] <= sum_d;
    end

    if (k < NumPipeRegs) begin : gen_prod
      always_ff @(posedge clk_i) begin
        if (!stall) prod_q[k] <= prod_q[k-1];
      end
    end
  end

  assign z_o.valid = valid_q[NumPipeRegs];
  assign z_o.data  = acc_q[NumPipeRegs];

endmodule

/* verilog/redmule_scheduler.sv */
// Job FSM steering X rows to the buffer and W/Y pairs to the engine
`timescale 1ns/10ps

module redmule_scheduler (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  redmule_cfg_pkg::job_cfg_t         job_cfg_i,
  input  redmule_bus_pkg::op_stream_t       op_i,
  output logic                              op_ready_o,
  input  logic                              engine_ready_i,
  input  logic                              z_fire_i,
  output logic                              x_load_o,
  output logic [redmule_cfg_pkg::ROW_W-1:0] x_row_o,
  output redmule_cfg_pkg::engine_req_t      engine_req_o,
  output logic                              job_done_o
);

  localparam int unsigned RowW = redmule_cfg_pkg::ROW_W;
  localparam logic [RowW-1:0] LastRow = RowW'(redmule_cfg_pkg::ARRAY_WIDTH - 1);

  typedef enum logic [2:0] {IDLE, LOAD_X, LOAD_W, LOAD_Y, DRAIN} state_e;

  state_e                             state_q;
  state_e                             state_d;
  logic [RowW-1:0]                    row_q;
  logic [redmule_cfg_pkg::SIZE_W-1:0] size_q;
  logic [redmule_cfg_pkg::SIZE_W-1:0] issue_cnt_q;
  logic [redmule_cfg_pkg::SIZE_W-1:0] z_cnt_q;
  logic [redmule_cfg_pkg::OP_W-1:0]   w_q;
  logic                               op_fire;
  logic                               last_issue;
  logic                               last_z;

  assign op_fire    = op_i.valid & op_ready_o;
  assign last_issue = issue_cnt_q == size_q - 1'b1;
  assign last_z     = z_cnt_q == size_q - 1'b1;
  assign job_done_o = (state_q != IDLE) & z_fire_i & last_z;

  always_comb begin
    state_d    = state_q;
    op_ready_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (job_cfg_i.start) state_d = LOAD_X;
      end
      LOAD_X: begin
        op_ready_o = 1'b1;
        if (op_i.valid && row_q == LastRow) state_d = LOAD_W;
      end
      LOAD_W: begin
        op_ready_o = 1'b1;
        if (op_i.valid) state_d = LOAD_Y;
      end
      LOAD_Y: begin
        // Y words wait for a free engine slot
        op_ready_o = engine_ready_i;
        if (op_i.valid && engine_ready_i) state_d = last_issue ? DRAIN : LOAD_W;
      end
      DRAIN: begin
        if (job_done_o) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  assign x_load_o           = (state_q == LOAD_X) & op_i.valid;
  assign x_row_o            = row_q;
  assign engine_req_o.valid = (state_q == LOAD_Y) & op_i.valid;
  assign engine_req_o.w     = w_q;
  assign engine_req_o.y     = op_i.data;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      row_q       <= '0;
      size_q      <= '0;
      issue_cnt_q <= '0;
      z_cnt_q     <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && job_cfg_i.start) begin
        row_q       <= '0;
        size_q      <= job_cfg_i.size_n;
        issue_cnt_q <= '0;
        z_cnt_q     <= '0;
      end
      if (x_load_o) row_q <= row_q + 1'b1;
      if (engine_req_o.valid && engine_ready_i) issue_cnt_q <= issue_cnt_q + 1'b1;
      // Results may leave while later pairs are still loading
      if (z_fire_i && state_q != IDLE) z_cnt_q <= z_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LOAD_W && op_fire) w_q <= op_i.data;
  end

endmodule

/* verilog/redmule_top.sv */
// Accelerator top level
// Connects the register slave, scheduler, X buffer and engine
`timescale 1ns/10ps

module redmule_top #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  redmule_bus_pkg::axil_req_t axil_req_i,
  output redmule_bus_pkg::axil_rsp_t axil_rsp_o,
  input  redmule_bus_pkg::op_stream_t op_i,
  output logic                       op_ready_o,
  output redmule_bus_pkg::z_stream_t z_o,
  input  logic                       z_ready_i,
  output logic                       busy_o,
  output logic                       evt_o
);

  redmule_cfg_pkg::job_cfg_t    job_cfg;
  redmule_cfg_pkg::x_matrix_t   x_matrix;
  redmule_cfg_pkg::engine_req_t engine_req;

  logic                              job_done;
  logic                              x_load;
  logic [redmule_cfg_pkg::ROW_W-1:0] x_row;
  logic                              engine_ready;
  logic                              z_fire;

  // Result handshake seen by the scheduler's counter
  assign z_fire = z_o.valid & z_ready_i;

  redmule_ctrl i_ctrl (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .axil_req_i ( axil_req_i ),
    .axil_rsp_o ( axil_rsp_o ),
    .job_done_i ( job_done   ),
    .job_cfg_o  ( job_cfg    ),
    .busy_o     ( busy_o     ),
    .evt_o      ( evt_o      )
  );

  redmule_scheduler i_scheduler (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .job_cfg_i      ( job_cfg      ),
    .op_i           ( op_i         ),
    .op_ready_o     ( op_ready_o   ),
    .engine_ready_i ( engine_ready ),
    .z_fire_i       ( z_fire       ),
    .x_load_o       ( x_load       ),
    .x_row_o        ( x_row        ),
    .engine_req_o   ( engine_req   ),
    .job_done_o     ( job_done     )
  );

  redmule_x_buffer i_x_buffer (
    .clk_i      ( clk_i     ),
    .arst_n_i   ( arst_n_i  ),
    .load_i     ( x_load    ),
    .row_i      ( x_row     ),
    .row_data_i ( op_i.data ),
    .x_o        ( x_matrix  )
  );

  redmule_engine #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_engine (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .x_i        ( x_matrix     ),
    .req_i      ( engine_req   ),
    .in_ready_o ( engine_ready ),
    .z_o        ( z_o          ),
    .z_ready_i  ( z_ready_i    )
  );

endmodule

/* verilog/redmule_x_buffer.sv */
// Stationary X matrix storage, loaded one row per input word
`timescale 1ns/10ps

module redmule_x_buffer (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              load_i,
  input  logic [redmule_cfg_pkg::ROW_W-1:0] row_i,
  input  logic [redmule_cfg_pkg::OP_W-1:0]  row_data_i,
  output redmule_cfg_pkg::x_matrix_t        x_o
);

  redmule_cfg_pkg::x_matrix_t x_q;

  // Matrix starts cleared and then holds for the whole job
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_q <= '0;
    end else if (load_i) begin
      x_q[row_i] <= row_data_i;
    end
  end

  assign x_o = x_q;

endmodule
